//--- files.f
cpuIsaPkg.sv
pipeCtrlPkg.sv
decodeMeta.sv
stageReg.sv
pipeTracker.sv
hazardDetect.sv
hazardCsr.sv
pipeCtrlTop.sv
pipeCtrlTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeline hazard-control simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary -f files.f --top-module pipeCtrlTb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

//--- pipeCtrlTb.sv
// Self-checking testbench for pipeCtrlTop; runs directed hazard tests then an LCG random stream
`timescale 1ns/1ps

module pipeCtrlTb;

  localparam int cntW          = 16;
  localparam int resetCycles   = 3;
  localparam int directedLimit = 150;   // Upper bound for all directed tests
  localparam int randomCycles  = 2000;
  localparam int timeoutNs     = (resetCycles + directedLimit + randomCycles) * 8 + 400;

  logic            clk = 1'b0;
  logic            reset;
  logic            fetchValid;
  logic [15:0]     fetchInstr;
  logic            icacheBusy;
  logic            dcacheBusy;
  logic            updatePc;
  logic            csrWrite;
  logic [1:0]      csrAddr;
  logic [cntW-1:0] csrWdata;
  logic            pcStall;
  logic            ifIdStall;
  logic            idExStall;
  logic            exMemStall;
  logic            memFlush;
  logic            idFlush;
  logic            ifFlush;
  logic [3:0]      memRd;
  logic            memRegWrite;
  logic            memEnable;
  logic            memWrite;
  logic [cntW-1:0] csrRdata;

  // Reference state; meta layout is {rd, regWrite, memEnable, memWrite, zEn, nvEn}
  logic            mIfValid;
  logic [15:0]     mIfInstr;
  logic [8:0]      mIdEx;
  logic [8:0]      mExMem;
  logic            mFwd;
  logic [cntW-1:0] mLu;
  logic [cntW-1:0] mBr;
  logic [8:0]      stepHaz;     // Used by the model update
  logic [8:0]      expHaz;      // Used by the compare process
  logic [3:0]      dS1;
  logic [3:0]      dS2;
  logic            dSt;
  logic            dBranch;
  logic            dBr;
  logic [8:0]      dMeta;
  logic [31:0]     rngState;
  logic [31:0]     r1;
  logic [31:0]     r2;
  string           testName;
  int              cmpErr;
  int              cmpChecks;
  int              dirErr;
  int              dirChecks;
  int              errAtStart;

  pipeCtrlTop #(.cntWidth(cntW)) DUT (.*);

  always #4 clk = ~clk;  // 8 ns period

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic void decodeRef(input logic v, input logic [15:0] ins,
                                    output logic [3:0] s1, output logic [3:0] s2,
                                    output logic st, output logic isBranch,
                                    output logic isBr, output logic [8:0] meta);
    logic [3:0] op;
    logic       zE;
    logic       nv;
    op       = ins[15:12];
    zE       = (op != 4'h3) && (op != 4'h7);  // RED and PADDSB leave flags alone
    nv       = (op == 4'h0) || (op == 4'h1);
    s1       = 4'd0;
    s2       = 4'd0;
    st       = 1'b0;
    isBranch = 1'b0;
    isBr     = 1'b0;
    meta     = 9'd0;
    if (v) begin
      case (op)
        4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
          s1   = ins[7:4];
          s2   = ins[3:0];
          meta = {ins[11:8], 1'b1, 1'b0, 1'b0, zE, nv};
        end
        4'h8: begin
          s1   = ins[7:4];
          meta = {ins[11:8], 5'b11000};  // Load writes rd
        end
        4'h9: begin
          s1   = ins[7:4];
          s2   = ins[11:8];              // Store data
          st   = 1'b1;
          meta = {4'd0, 5'b01100};
        end
        4'hA, 4'hB: begin
          s1   = ins[11:8];
          meta = {ins[11:8], 5'b10000};
        end
        4'hC: isBranch = 1'b1;
        4'hD: begin
          s1       = ins[7:4];
          isBranch = 1'b1;
          isBr     = 1'b1;
        end
        4'hE: meta = {ins[11:8], 5'b10000};
        default: ;
      endcase
    end
  endfunction

  // {pcStall, ifIdStall, idExStall, exMemStall, memFlush, idFlush, ifFlush, loadUse, branch}
  function automatic logic [8:0] refHazard(input logic icb, input logic dcb, input logic upc);
    logic [3:0] s1;
    logic [3:0] s2;
    logic       st;
    logic       isBranch;
    logic       isBr;
    logic [8:0] meta;
    logic       flagBusy;
    logic       lu;
    logic       bh;
    logic       brh;
    logic       hold;
    decodeRef(mIfValid, mIfInstr, s1, s2, st, isBranch, isBr, meta);
    flagBusy = mIdEx[1] | mIdEx[0];
    lu  = mIdEx[3] && !mIdEx[2] && (mIdEx[8:5] != 4'd0) &&
          ((mIdEx[8:5] == s1) || ((mIdEx[8:5] == s2) && !(st && mFwd)));
    bh  = isBranch && flagBusy;
    brh = isBr && (flagBusy ||
                   (mIdEx[4] && (mIdEx[8:5] != 4'd0) && (mIdEx[8:5] == s1)) ||
                   (mExMem[4] && (mExMem[8:5] != 4'd0) && (mExMem[8:5] == s1)));
    hold = dcb | lu | bh | brh;
    return {icb | hold, hold, dcb, dcb, dcb, lu | bh | brh, icb | (upc & ~hold), lu, bh | brh};
  endfunction

  function automatic logic [cntW-1:0] csrRef(input logic [1:0] addr);
    case (addr)
      2'd0:    return {{(cntW-1){1'b0}}, mFwd};
      2'd1:    return mLu;
      2'd2:    return mBr;
      default: return '0;  // Unmapped
    endcase
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      mIfValid <= 1'b0;
      mIfInstr <= 16'd0;
      mIdEx    <= 9'd0;
      mExMem   <= 9'd0;
      mFwd     <= 1'b1;
      mLu      <= '0;
      mBr      <= '0;
    end else begin
      stepHaz = refHazard(icacheBusy, dcacheBusy, updatePc);
      decodeRef(mIfValid, mIfInstr, dS1, dS2, dSt, dBranch, dBr, dMeta);
      if (stepHaz[2]) begin        // ifFlush beats stall
        mIfValid <= 1'b0;
        mIfInstr <= 16'd0;
      end else if (!stepHaz[7]) begin
        mIfValid <= fetchValid;
        mIfInstr <= fetchInstr;
      end
      if (!stepHaz[6])
        mIdEx <= stepHaz[3] ? 9'd0 : dMeta;
      if (!stepHaz[5])
        mExMem <= mIdEx;
      if (csrWrite && csrAddr == 2'd0)
        mFwd <= csrWdata[0];
      if (csrWrite && csrAddr == 2'd1)
        mLu <= '0;
      else if (stepHaz[1])
        mLu <= mLu + 16'd1;
      if (csrWrite && csrAddr == 2'd2)
        mBr <= '0;
      else if (stepHaz[0])
        mBr <= mBr + 16'd1;
    end
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  function automatic int mismatch(input string sig, input logic [15:0] expV,
                                  input logic [15:0] actV);
    if (expV !== actV) begin
      $display("ERR %s %s expected %h actual %h", testName, sig, expV, actV);
      return 1;
    end
    return 0;
  endfunction

  // Samples on the falling edge ahead of the new stimulus
  always @(negedge clk) begin
    if (!reset) begin
      expHaz = refHazard(icacheBusy, dcacheBusy, updatePc);
      cmpErr += mismatch("pcStall", {15'd0, expHaz[8]}, {15'd0, pcStall});
      cmpErr += mismatch("ifIdStall", {15'd0, expHaz[7]}, {15'd0, ifIdStall});
      cmpErr += mismatch("idExStall", {15'd0, expHaz[6]}, {15'd0, idExStall});
      cmpErr += mismatch("exMemStall", {15'd0, expHaz[5]}, {15'd0, exMemStall});
      cmpErr += mismatch("memFlush", {15'd0, expHaz[4]}, {15'd0, memFlush});
      cmpErr += mismatch("idFlush", {15'd0, expHaz[3]}, {15'd0, idFlush});
      cmpErr += mismatch("ifFlush", {15'd0, expHaz[2]}, {15'd0, ifFlush});
      cmpErr += mismatch("memRd", {12'd0, mExMem[8:5]}, {12'd0, memRd});
      cmpErr += mismatch("memRegWrite", {15'd0, mExMem[4]}, {15'd0, memRegWrite});
      cmpErr += mismatch("memEnable", {15'd0, mExMem[3]}, {15'd0, memEnable});
      cmpErr += mismatch("memWrite", {15'd0, mExMem[2]}, {15'd0, memWrite});
      cmpErr += mismatch("csrRdata", csrRef(csrAddr), csrRdata);
      cmpChecks += 12;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  function logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  task automatic drive(input logic fv, input logic [15:0] ins, input logic icb,
                       input logic dcb, input logic upc);
    @(negedge clk);
    fetchValid <= fv;
    fetchInstr <= ins;
    icacheBusy <= icb;
    dcacheBusy <= dcb;
    updatePc   <= upc;
    csrWrite   <= 1'b0;
  endtask

  task automatic issue(input logic [15:0] ins);
    drive(1'b1, ins, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) drive(1'b0, 16'd0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic writeCsr(input logic [1:0] addr, input logic [cntW-1:0] data);
    drive(1'b0, 16'd0, 1'b0, 1'b0, 1'b0);
    csrWrite <= 1'b1;  // One-cycle strobe
    csrAddr  <= addr;
    csrWdata <= data;
  endtask

  task automatic checkCsr(input logic [1:0] addr, input logic [cntW-1:0] expV);
    drive(1'b0, 16'd0, 1'b0, 1'b0, 1'b0);
    csrAddr <= addr;
    @(negedge clk);
    dirErr += mismatch($sformatf("csr[%0d]", addr), expV, csrRdata);
    dirChecks++;
  endtask

  task automatic startTest(input string name);
    testName   = name;
    errAtStart = cmpErr + dirErr;
  endtask

  task automatic finishTest();
    int n;
    @(posedge clk);  // Last driven cycle is compared at the falling edge in between
    @(posedge clk);
    n = cmpErr + dirErr - errAtStart;
    $display("%s: %s, %0d errors", testName, (n == 0) ? "ok" : "mismatch", n);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  initial begin
    rngState   = 32'ha268_d256;
    testName   = "reset";
    cmpErr     = 0;
    cmpChecks  = 0;
    dirErr     = 0;
    dirChecks  = 0;
    errAtStart = 0;
    reset      <= 1'b1;
    fetchValid <= 1'b0;
    fetchInstr <= 16'd0;
    icacheBusy <= 1'b0;
    dcacheBusy <= 1'b0;
    updatePc   <= 1'b0;
    csrWrite   <= 1'b0;
    csrAddr    <= 2'd0;
    csrWdata   <= '0;
    repeat (resetCycles) @(negedge clk);
    reset <= 1'b0;

    startTest("reset");
    idleCycles(2);
    @(negedge clk);
    dirErr += mismatch("stallFlush", 16'd0,
                       {9'd0, pcStall, ifIdStall, idExStall, exMemStall,
                        memFlush, idFlush, ifFlush});
    dirChecks++;
    checkCsr(2'd0, 16'd1);       // storeFwdEn comes up set
    checkCsr(2'd1, 16'd0);
    checkCsr(2'd2, 16'd0);
    checkCsr(2'd3, 16'd0);
    finishTest();

    startTest("loadUse");
    writeCsr(2'd1, '0);
    issue(16'h8510);             // LW r5
    issue(16'h0352);             // ADD r3, r5, r2 stalls once
    idleCycles(3);
    issue(16'h8010);             // LW r0 is never a hazard
    issue(16'h0302);
    idleCycles(3);
    issue(16'h8510);
    issue(16'h9510);             // SW r5 forwarded
    idleCycles(3);
    writeCsr(2'd0, '0);          // Forwarding off
    issue(16'h8510);
    issue(16'h9510);             // Now stalls
    idleCycles(3);
    writeCsr(2'd0, 16'd1);
    checkCsr(2'd1, 16'd2);
    finishTest();

    startTest("branch");
    writeCsr(2'd2, '0);
    issue(16'h0352);             // ADD sets flags
    issue(16'hC000);             // B waits one cycle
    idleCycles(3);
    issue(16'hA712);             // LLB r7
    issue(16'hD070);             // BR r7 waits for EX and MEM
    idleCycles(4);
    checkCsr(2'd2, 16'd3);
    writeCsr(2'd2, '0);
    checkCsr(2'd2, 16'd0);
    finishTest();

    startTest("cacheRedirect");
    issue(16'h8510);
    idleCycles(2);               // LW reaches EX/MEM
    repeat (3) drive(1'b0, 16'd0, 1'b0, 1'b1, 1'b0);
    idleCycles(2);
    repeat (2) drive(1'b1, 16'h0123, 1'b1, 1'b0, 1'b0);
    drive(1'b1, 16'h0456, 1'b0, 1'b0, 1'b1);  // Redirect with decode free
    idleCycles(2);
    issue(16'hA712);
    issue(16'hD070);
    drive(1'b0, 16'd0, 1'b0, 1'b0, 1'b1);     // Redirect during BR stall
    idleCycles(3);
    finishTest();

    startTest("random");
    repeat (randomCycles) begin
      r1 = nextRand();
      r2 = nextRand();
      drive(r1[1:0] != 2'b00, r2[31:16], r1[11:9] == 3'd0, r1[14:12] == 3'd0,
            r1[18:15] == 4'd0);
      csrAddr  <= r1[21:20];
      csrWrite <= (r1[26:22] == 5'd0);
      csrWdata <= {15'd0, r1[27]};
    end
    idleCycles(2);
    finishTest();

    $display("checks %0d, errors %0d", cmpChecks + dirChecks, cmpErr + dirErr);
    if (cmpErr + dirErr == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog sized from reset, directed and random cycle counts
  initial begin
    #(timeoutNs);
    $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
    $display("sim failed");
    $finish;
  end

endmodule

//--- pipeCtrlTop.sv
// Top of the hazard-control subsystem, wiring tracker, hazard unit and CSR block together
`timescale 1ns/1ps

module pipeCtrlTop #(
  parameter int cntWidth = 16  // Hazard counter width
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetchValid,
  input  cpuIsaPkg::instrT     fetchInstr,
  input  logic                 icacheBusy,
  input  logic                 dcacheBusy,
  input  logic                 updatePc,
  input  logic                 csrWrite,
  input  pipeCtrlPkg::csrAddrT csrAddr,
  input  logic [cntWidth-1:0]  csrWdata,
  output logic                 pcStall,
  output logic                 ifIdStall,
  output logic                 idExStall,
  output logic                 exMemStall,
  output logic                 memFlush,
  output logic                 idFlush,
  output logic                 ifFlush,
  output cpuIsaPkg::regIdT     memRd,        // EX/MEM view for MEM and WB
  output logic                 memRegWrite,
  output logic                 memEnable,
  output logic                 memWrite,
  output logic [cntWidth-1:0]  csrRdata
);

  cpuIsaPkg::regIdT       srcReg1;
  cpuIsaPkg::regIdT       srcReg2;
  logic                   idMemWrite;
  logic                   idBranch;
  logic                   idBr;
  pipeCtrlPkg::stageMetaT idExMeta;
  pipeCtrlPkg::stageMetaT exMemMeta;
  logic                   storeFwdEn;
  logic                   loadUseHazard;
  logic                   branchHazard;

  pipeTracker tracker (
    .clk        (clk),
    .reset      (reset),
    .fetchValid (fetchValid),
    .fetchInstr (fetchInstr),
    .ifIdStall  (ifIdStall),
    .idExStall  (idExStall),
    .exMemStall (exMemStall),
    .ifFlush    (ifFlush),
    .idFlush    (idFlush),
    .srcReg1    (srcReg1),
    .srcReg2    (srcReg2),
    .idMemWrite (idMemWrite),
    .idBranch   (idBranch),
    .idBr       (idBr),
    .idExMeta   (idExMeta),
    .exMemMeta  (exMemMeta)
  );

  hazardDetect hazard (
    .srcReg1       (srcReg1),
    .srcReg2       (srcReg2),
    .idMemWrite    (idMemWrite),
    .idBranch      (idBranch),
    .idBr          (idBr),
    .idExMeta      (idExMeta),
    .exMemMeta     (exMemMeta),
    .icacheBusy    (icacheBusy),
    .dcacheBusy    (dcacheBusy),
    .updatePc      (updatePc),
    .storeFwdEn    (storeFwdEn),
    .pcStall       (pcStall),
    .ifIdStall     (ifIdStall),
    .idExStall     (idExStall),
    .exMemStall    (exMemStall),
    .memFlush      (memFlush),
    .idFlush       (idFlush),
    .ifFlush       (ifFlush),
    .loadUseHazard (loadUseHazard),
    .branchHazard  (branchHazard)
  );

  hazardCsr #(.cntWidth(cntWidth)) csr (
    .clk           (clk),
    .reset         (reset),
    .csrWrite      (csrWrite),
    .csrAddr       (csrAddr),
    .csrWdata      (csrWdata),
    .loadUseHazard (loadUseHazard),
    .branchHazard  (branchHazard),
    .storeFwdEn    (storeFwdEn),
    .csrRdata      (csrRdata)
  );

  // EX/MEM fields out to the memory stage
  assign memRd       = exMemMeta.rd;
  assign memRegWrite = exMemMeta.regWrite;
  assign memEnable   = exMemMeta.memEnable;
  assign memWrite    = exMemMeta.memWrite;

endmodule

//--- hazardCsr.sv
// CSR block holding the store-forwarding enable and hazard cycle counters behind a strobe port
`timescale 1ns/1ps

module hazardCsr #(
  parameter int cntWidth = 16  // Counter and data width
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 csrWrite,       // One-cycle write strobe
  input  pipeCtrlPkg::csrAddrT csrAddr,
  input  logic [cntWidth-1:0]  csrWdata,
  input  logic                 loadUseHazard,  // Counted each cycle high
  input  logic                 branchHazard,
  output logic                 storeFwdEn,
  output logic [cntWidth-1:0]  csrRdata        // Same-cycle read
);

  logic [cntWidth-1:0] loadUseCnt;
  logic [cntWidth-1:0] branchCnt;

  ////////////////////////////////////////
  // Config and counters
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      storeFwdEn <= pipeCtrlPkg::storeFwdReset;
      loadUseCnt <= '0;
      branchCnt  <= '0;
    end else begin
      if (csrWrite && csrAddr == pipeCtrlPkg::cfgAddr)
        storeFwdEn <= csrWdata[0];

      // Write clears, and wins over a same-cycle increment
      if (csrWrite && csrAddr == pipeCtrlPkg::loadUseCntAddr)
        loadUseCnt <= '0;
      else if (loadUseHazard)
        loadUseCnt <= loadUseCnt + cntWidth'(1);  // Wraps

      if (csrWrite && csrAddr == pipeCtrlPkg::branchCntAddr)
        branchCnt <= '0;
      else if (branchHazard)
        branchCnt <= branchCnt + cntWidth'(1);
    end
  end

  // Read mux with unmapped addresses reading zero
  always_comb begin
    case (csrAddr)
      pipeCtrlPkg::cfgAddr:        csrRdata = {{(cntWidth-1){1'b0}}, storeFwdEn};
      pipeCtrlPkg::loadUseCntAddr: csrRdata = loadUseCnt;
      pipeCtrlPkg::branchCntAddr:  csrRdata = branchCnt;
      default:                     csrRdata = '0;
    endcase
  end

endmodule

//--- hazardDetect.sv
// Combinational hazard unit producing every pipeline stall and flush from stage state
`timescale 1ns/1ps

module hazardDetect (
  input  cpuIsaPkg::regIdT       srcReg1,       // ID read register 1
  input  cpuIsaPkg::regIdT       srcReg2,       // ID read register 2
  input  logic                   idMemWrite,    // ID is a store
  input  logic                   idBranch,      // ID is B or BR
  input  logic                   idBr,          // ID is BR
  input  pipeCtrlPkg::stageMetaT idExMeta,
  input  pipeCtrlPkg::stageMetaT exMemMeta,
  input  logic                   icacheBusy,    // Fetch miss in progress
  input  logic                   dcacheBusy,    // Data miss, whole pipe holds
  input  logic                   updatePc,      // Redirect from a taken branch
  input  logic                   storeFwdEn,    // MEM-MEM forwarding for store data
  output logic                   pcStall,
  output logic                   ifIdStall,
  output logic                   idExStall,
  output logic                   exMemStall,
  output logic                   memFlush,      // Bubble into MEM/WB
  output logic                   idFlush,       // Bubble into ID/EX
  output logic                   ifFlush,       // Bubble into IF/ID
  output logic                   loadUseHazard,
  output logic                   branchHazard   // B or BR hazard, for the counter
);

  logic idExMemRead;    // LW sitting in EX
  logic storeDataFwd;   // Store data can come from MEM-MEM path
  logic flagBusy;       // EX will change condition codes
  logic exToIdBr;       // EX writes the BR target register
  logic memToIdBr;      // MEM writes the BR target register
  logic bHazard;
  logic brHazard;

  ////////////////////////////////////////
  // Load to use
  ////////////////////////////////////////
  assign idExMemRead  = idExMeta.memEnable & ~idExMeta.memWrite;
  assign storeDataFwd = idMemWrite & storeFwdEn;

  assign loadUseHazard = idExMemRead & (idExMeta.rd != cpuIsaPkg::zeroReg) &
                         ((idExMeta.rd == srcReg1) |
                          ((idExMeta.rd == srcReg2) & ~storeDataFwd));

  ////////////////////////////////////////
  // B and BR
  ////////////////////////////////////////
  assign flagBusy = idExMeta.zEn | idExMeta.nvEn;

  assign exToIdBr  = idExMeta.regWrite & (idExMeta.rd != cpuIsaPkg::zeroReg) &
                     (idExMeta.rd == srcReg1);
  assign memToIdBr = exMemMeta.regWrite & (exMemMeta.rd != cpuIsaPkg::zeroReg) &
                     (exMemMeta.rd == srcReg1);

  assign bHazard  = idBranch & flagBusy;                        // Flags not yet settled
  assign brHazard = idBr & (flagBusy | exToIdBr | memToIdBr);  // Target not yet written

  assign branchHazard = bHazard | brHazard;

  ////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////
  assign exMemStall = dcacheBusy;
  assign idExStall  = exMemStall;
  assign ifIdStall  = exMemStall | loadUseHazard | bHazard | brHazard;
  assign pcStall    = icacheBusy | ifIdStall;

  ////////////////////////////////////////
  // Flushes
  ////////////////////////////////////////
  assign memFlush = dcacheBusy;
  assign idFlush  = loadUseHazard | bHazard | brHazard;  // NOP into EX
  // Redirect only squashes fetch when decode is free to move
  assign ifFlush  = icacheBusy | (updatePc & ~ifIdStall);

endmodule

//--- pipeTracker.sv
// Holds IF/ID, ID/EX and EX/MEM and exports the decoded ID fields to the hazard unit
`timescale 1ns/1ps

module pipeTracker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetchValid,   // One-cycle strobe, no back-pressure
  input  cpuIsaPkg::instrT       fetchInstr,
  input  logic                   ifIdStall,
  input  logic                   idExStall,
  input  logic                   exMemStall,
  input  logic                   ifFlush,
  input  logic                   idFlush,
  output cpuIsaPkg::regIdT       srcReg1,      // ID read registers
  output cpuIsaPkg::regIdT       srcReg2,
  output logic                   idMemWrite,   // ID holds a store
  output logic                   idBranch,     // ID holds B or BR
  output logic                   idBr,         // ID holds BR
  output pipeCtrlPkg::stageMetaT idExMeta,
  output pipeCtrlPkg::stageMetaT exMemMeta
);

  logic                   ifIdValid;
  cpuIsaPkg::instrT       ifIdInstr;
  pipeCtrlPkg::stageMetaT idMeta;      // Decoded, not yet registered
  logic                   idExValid;
  pipeCtrlPkg::stageMetaT idExData;
  logic                   exMemValid;
  pipeCtrlPkg::stageMetaT exMemData;
  logic                   ifIdHold;

  ////////////////////////////////////////
  // IF/ID
  ////////////////////////////////////////
  assign ifIdHold = ifIdStall & ~ifFlush;  // Flush beats stall in this stage only

  stageReg #(.payloadT(cpuIsaPkg::instrT)) ifIdReg (
    .clk      (clk),
    .reset    (reset),
    .stall    (ifIdHold),
    .flush    (ifFlush),
    .inValid  (fetchValid),  // Word dropped if offered during a stall
    .inData   (fetchInstr),
    .outValid (ifIdValid),
    .outData  (ifIdInstr)
  );

  // ID decode, bubble in gives metaBubble out
  decodeMeta idDecode (
    .instr    (ifIdInstr),
    .valid    (ifIdValid),
    .srcReg1  (srcReg1),
    .srcReg2  (srcReg2),
    .meta     (idMeta),
    .memWrite (idMemWrite),
    .branch   (idBranch),
    .br       (idBr)
  );

  ////////////////////////////////////////
  // ID/EX and EX/MEM
  ////////////////////////////////////////
  stageReg #(.payloadT(pipeCtrlPkg::stageMetaT)) idExReg (
    .clk      (clk),
    .reset    (reset),
    .stall    (idExStall),  // Hold wins over hazard flush
    .flush    (idFlush),
    .inValid  (ifIdValid),
    .inData   (idMeta),
    .outValid (idExValid),
    .outData  (idExData)
  );

  stageReg #(.payloadT(pipeCtrlPkg::stageMetaT)) exMemReg (
    .clk      (clk),
    .reset    (reset),
    .stall    (exMemStall),
    .flush    (1'b0),        // MEM/WB takes the bubble instead
    .inValid  (idExValid),
    .inData   (idExData),
    .outValid (exMemValid),
    .outData  (exMemData)
  );

  // Empty stages always present as bubbles
  assign idExMeta  = idExValid  ? idExData  : pipeCtrlPkg::metaBubble;
  assign exMemMeta = exMemValid ? exMemData : pipeCtrlPkg::metaBubble;

endmodule

//--- stageReg.sv
// Generic pipeline register with stall hold and flush to bubble; one per tracked stage
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic  // Instruction word or stage metadata
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    stall,     // Hold current contents
  input  logic    flush,     // Load a bubble
  input  logic    inValid,
  input  payloadT inData,
  output logic    outValid,
  output payloadT outData
);

  // Stall wins over flush here; pipeTracker masks stall where flush must win
  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;  // Empty after reset
      outData  <= '0;
    end else if (!stall) begin
      if (flush) begin
        outValid <= 1'b0;
        outData  <= '0;
      end else begin
        outValid <= inValid;
        outData  <= inData;
      end
    end
  end

endmodule

//--- decodeMeta.sv
// Decodes the IF/ID word into hazard-check fields; instantiated once inside pipeTracker
`timescale 1ns/1ps

module decodeMeta (
  input  cpuIsaPkg::instrT       instr,     // IF/ID instruction word
  input  logic                   valid,     // IF/ID holds a real instruction
  output cpuIsaPkg::regIdT       srcReg1,   // rs, base, or rd for LLB/LHB
  output cpuIsaPkg::regIdT       srcReg2,   // rt or store data register
  output pipeCtrlPkg::stageMetaT meta,      // Goes into ID/EX
  output logic                   memWrite,  // ID instruction is a store
  output logic                   branch,    // B or BR
  output logic                   br         // BR only
);

  cpuIsaPkg::opcodeT opcode;
  cpuIsaPkg::regIdT  rdField;
  cpuIsaPkg::regIdT  rsField;
  cpuIsaPkg::regIdT  rtField;

  assign opcode  = instr[cpuIsaPkg::opMsb:cpuIsaPkg::opLsb];
  assign rdField = instr[cpuIsaPkg::rdMsb:cpuIsaPkg::rdLsb];
  assign rsField = instr[cpuIsaPkg::rsMsb:cpuIsaPkg::rsLsb];
  assign rtField = instr[cpuIsaPkg::rtMsb:cpuIsaPkg::rtLsb];

  always_comb begin
    // Default is a bubble that reads and writes nothing
    srcReg1  = cpuIsaPkg::zeroReg;
    srcReg2  = cpuIsaPkg::zeroReg;
    meta     = pipeCtrlPkg::metaBubble;
    memWrite = 1'b0;
    branch   = 1'b0;
    br       = 1'b0;

    if (valid) begin
      case (opcode)
        cpuIsaPkg::opAdd, cpuIsaPkg::opSub, cpuIsaPkg::opXor, cpuIsaPkg::opRed,
        cpuIsaPkg::opSll, cpuIsaPkg::opSra, cpuIsaPkg::opRor, cpuIsaPkg::opPaddsb: begin
          srcReg1       = rsField;
          srcReg2       = rtField;
          meta.rd       = rdField;
          meta.regWrite = 1'b1;
          // Flag enables per ALU op
          meta.zEn  = (opcode != cpuIsaPkg::opRed) && (opcode != cpuIsaPkg::opPaddsb);
          meta.nvEn = (opcode == cpuIsaPkg::opAdd) || (opcode == cpuIsaPkg::opSub);
        end
        cpuIsaPkg::opLw: begin
          srcReg1        = rsField;  // Base
          meta.rd        = rdField;
          meta.regWrite  = 1'b1;
          meta.memEnable = 1'b1;
        end
        cpuIsaPkg::opSw: begin
          srcReg1        = rsField;  // Base
          srcReg2        = rdField;  // Store data
          meta.memEnable = 1'b1;
          meta.memWrite  = 1'b1;
          memWrite       = 1'b1;
        end
        cpuIsaPkg::opLlb, cpuIsaPkg::opLhb: begin
          srcReg1       = rdField;  // Half of rd is kept
          meta.rd       = rdField;
          meta.regWrite = 1'b1;
        end
        cpuIsaPkg::opB: begin
          branch = 1'b1;
        end
        cpuIsaPkg::opBr: begin
          srcReg1 = rsField;  // Target register
          branch  = 1'b1;
          br      = 1'b1;
        end
        cpuIsaPkg::opPcs: begin
          meta.rd       = rdField;
          meta.regWrite = 1'b1;
        end
        default: ;  // HLT touches nothing
      endcase
    end
  end

endmodule

//--- pipeCtrlPkg.sv
// Pipeline-control types and CSR map shared by the tracker, hazard unit and CSR block
package pipeCtrlPkg;

  ////////////////////////////////////////
  // Stage metadata
  ////////////////////////////////////////
  // What the hazard unit needs to know about an instruction past ID
  typedef struct packed {
    cpuIsaPkg::regIdT rd;  // Destination register
    logic regWrite;        // Writes rd
    logic memEnable;       // LW or SW
    logic memWrite;        // SW only
    logic zEn;             // Updates Z flag
    logic nvEn;            // Updates N and V flags
  } stageMetaT;

  localparam stageMetaT metaBubble = '0;  // NOP in ID/EX or EX/MEM

  ////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////
  localparam int csrAddrWidth = 2;
  typedef logic [csrAddrWidth-1:0] csrAddrT;

  localparam csrAddrT cfgAddr        = 2'd0;  // Bit 0 is storeFwdEn
  localparam csrAddrT loadUseCntAddr = 2'd1;  // Load-to-use stall cycles
  localparam csrAddrT branchCntAddr  = 2'd2;  // B/BR stall cycles

  localparam logic storeFwdReset = 1'b1;  // MEM-MEM forwarding on out of reset

endpackage

//--- cpuIsaPkg.sv
// Instruction-set constants for the 16-bit core, referenced by decode logic and testbench
package cpuIsaPkg;

  ////////////////////////////////////////
  // Widths and base types
  ////////////////////////////////////////
  localparam int regIdWidth = 4;   // Sixteen registers
  localparam int instrWidth = 16;  // One instruction word

  typedef logic [regIdWidth-1:0] regIdT;
  typedef logic [instrWidth-1:0] instrT;
  typedef logic [3:0]            opcodeT;

  localparam regIdT zeroReg = '0;  // r0 always reads as zero

  ////////////////////////////////////////
  // Field positions
  ////////////////////////////////////////
  localparam int opMsb = 15;
  localparam int opLsb = 12;
  localparam int rdMsb = 11;  // Also store data register
  localparam int rdLsb = 8;
  localparam int rsMsb = 7;   // Also load/store base
  localparam int rsLsb = 4;
  localparam int rtMsb = 3;
  localparam int rtLsb = 0;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  localparam opcodeT opAdd    = 4'h0;  // Sets Z, N, V
  localparam opcodeT opSub    = 4'h1;  // Sets Z, N, V
  localparam opcodeT opXor    = 4'h2;  // Sets Z
  localparam opcodeT opRed    = 4'h3;
  localparam opcodeT opSll    = 4'h4;  // Sets Z
  localparam opcodeT opSra    = 4'h5;  // Sets Z
  localparam opcodeT opRor    = 4'h6;  // Sets Z
  localparam opcodeT opPaddsb = 4'h7;
  localparam opcodeT opLw     = 4'h8;
  localparam opcodeT opSw     = 4'h9;
  localparam opcodeT opLlb    = 4'hA;  // Reads and writes rd
  localparam opcodeT opLhb    = 4'hB;  // Reads and writes rd
  localparam opcodeT opB      = 4'hC;  // Conditional branch on flags
  localparam opcodeT opBr     = 4'hD;  // Branch to register
  localparam opcodeT opPcs    = 4'hE;
  localparam opcodeT opHlt    = 4'hF;

endpackage
